//--- list.f
hw/mem_pkg.sv
hw/byte_lane_aligner.sv
hw/memory_controller.sv
hw/wait_state_ram.sv
hw/mem_subsystem.sv
tb/mem_subsystem_checker.sv
tb/tb_mem_subsystem.sv

//--- run.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert \
  --top-module tb_mem_subsystem \
  -Mdir obj_dir \
  -f list.f

./obj_dir/Vtb_mem_subsystem 2>&1 | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "Simulation passed."
  exit 0
else
  echo "Simulation failed, see sim.log."
  exit 1
fi

//--- tb/tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem
  import mem_pkg::*;
();

  localparam int WAIT_CYCLES    = 2;
  localparam int TIMEOUT_CYCLES = 40;

  logic              CLK;
  logic              nRST;
  logic              i_d_ren;
  logic              i_d_wen;
  logic [ADDR_W-1:0] i_d_addr;
  logic [BE_W-1:0]   i_d_byte_en;
  logic [DATA_W-1:0] i_d_wdata;
  logic [DATA_W-1:0] o_d_rdata;
  logic              o_d_busy;
  logic              i_i_ren;
  logic [ADDR_W-1:0] i_i_addr;
  logic [DATA_W-1:0] o_i_rdata;
  logic              o_i_busy;

  // Words as they sit in the RAM, in bus byte order.
  logic [DATA_W-1:0] ref_mem [256];
  integer            seed;
  int                errors;

  mem_subsystem #(
    .BUS_ENDIANNESS ("little"),
    .RAM_WORDS      (256),
    .WAIT_CYCLES    (WAIT_CYCLES)
  ) u_dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_d_ren     (i_d_ren),
    .i_d_wen     (i_d_wen),
    .i_d_addr    (i_d_addr),
    .i_d_byte_en (i_d_byte_en),
    .i_d_wdata   (i_d_wdata),
    .o_d_rdata   (o_d_rdata),
    .o_d_busy    (o_d_busy),
    .i_i_ren     (i_i_ren),
    .i_i_addr    (i_i_addr),
    .o_i_rdata   (o_i_rdata),
    .o_i_busy    (o_i_busy)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A little-endian bus sees the bytes of each word in reverse order.
  function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Word aligned byte address inside the 256 word RAM.
  function automatic logic [31:0] random_addr();
    logic [31:0] r;
    r = $random(seed);
    return {22'd0, r[7:0], 2'b00};
  endfunction

  // Applies one write to the reference array by the byte order and lane rules.
  task automatic ref_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] lanes;
    lanes = reverse_bytes(wdata);
    case (be)
      4'b0010:          lanes = lanes << 8;
      4'b0100, 4'b1100: lanes = lanes << 16;
      4'b1000:          lanes = lanes << 24;
      default:          lanes = lanes;
    endcase
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ref_mem[addr[9:2]][8*b +: 8] = lanes[8*b +: 8];
      end
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] exp,
                            input logic [31:0] got);
    if (got !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic idle_ports();
    i_d_ren     = 1'b0;
    i_d_wen     = 1'b0;
    i_d_addr    = '0;
    i_d_byte_en = '0;
    i_d_wdata   = '0;
    i_i_ren     = 1'b0;
    i_i_addr    = '0;
  endtask

  // One access on one port from an idle bus, with a latency check.
  task automatic run_access(input bit instr, input bit wr, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int cycles;
    bit done;
    if (instr) begin
      i_i_ren  = 1'b1;
      i_i_addr = addr;
    end else begin
      i_d_ren     = !wr;
      i_d_wen     = wr;
      i_d_addr    = addr;
      i_d_byte_en = be;
      i_d_wdata   = wdata;
    end
    cycles = 0;
    done   = 1'b0;
    rdata  = '0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      cycles++;
      if (instr ? !o_i_busy : !o_d_busy) begin
        done  = 1'b1;
        rdata = instr ? o_i_rdata : o_d_rdata;
      end
    end
    if (!done) begin
      $display("Timeout at %0t: port busy never went low for address %h", $time, addr);
      errors++;
    end else if (cycles != WAIT_CYCLES + 1) begin
      $display("mismatch at %0t: latency expected %0d got %0d", $time, WAIT_CYCLES + 1,
               cycles);
      errors++;
    end
    if (done && wr) begin
      ref_write(addr, be, wdata);
    end
    // The access completes on the next rising edge.
    @(negedge CLK);
    idle_ports();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_test();
    for (int n = 0; n < 5; n++) begin
      @(negedge CLK);
      if (!o_d_busy || !o_i_busy) begin
        $display("mismatch at %0t: busy expected 11 got %b%b", $time, o_d_busy, o_i_busy);
        errors++;
      end
    end
  endtask

  task automatic round_trip_test();
    logic [31:0] addrs [8];
    logic [31:0] rdata;
    for (int n = 0; n < 8; n++) begin
      addrs[n] = random_addr();
      run_access(1'b0, 1'b1, addrs[n], 4'b1111, $random(seed), rdata);
    end
    for (int n = 0; n < 8; n++) begin
      run_access(1'b0, 1'b0, addrs[n], 4'b1111, '0, rdata);
      check_word("round trip", reverse_bytes(ref_mem[addrs[n][9:2]]), rdata);
    end
  endtask

  task automatic partial_write_test();
    logic [3:0]  enables [6];
    logic [31:0] addr;
    logic [31:0] rdata;
    enables = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
    foreach (enables[n]) begin
      addr = random_addr();
      run_access(1'b0, 1'b1, addr, 4'b1111, $random(seed), rdata);
      run_access(1'b0, 1'b1, addr, enables[n], $random(seed), rdata);
      run_access(1'b0, 1'b0, addr, 4'b1111, '0, rdata);
      check_word("partial write", reverse_bytes(ref_mem[addr[9:2]]), rdata);
    end
  endtask

  task automatic fetch_test();
    logic [31:0] addr;
    logic [31:0] rdata;
    for (int n = 0; n < 6; n++) begin
      addr = random_addr();
      run_access(1'b0, 1'b1, addr, 4'b1111, $random(seed), rdata);
      run_access(1'b1, 1'b0, addr, 4'b1111, '0, rdata);
      check_word("fetch", reverse_bytes(ref_mem[addr[9:2]]), rdata);
    end
  endtask

  // A write and a fetch start together, and a read follows the write at once.
  // Expected order is write, fetch, read.
  task automatic contention_test();
    logic [31:0] d_addr;
    logic [31:0] f_addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    int          order [3];
    int          seen;
    int          cycles;
    int          d_step;
    bit          d_next;
    bit          f_done;
    bit          f_next;
    d_addr = random_addr();
    f_addr = d_addr ^ 32'h4;
    run_access(1'b0, 1'b1, f_addr, 4'b1111, $random(seed), rdata);
    wdata       = $random(seed);
    i_d_wen     = 1'b1;
    i_d_addr    = d_addr;
    i_d_byte_en = 4'b1111;
    i_d_wdata   = wdata;
    i_i_ren     = 1'b1;
    i_i_addr    = f_addr;
    seen   = 0;
    cycles = 0;
    d_step = 0;
    d_next = 1'b0;
    f_done = 1'b0;
    f_next = 1'b0;
    while ((d_step < 2 || !f_done) && cycles < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      cycles++;
      if (d_next) begin
        d_next  = 1'b0;
        i_d_wen = 1'b0;
        i_d_ren = (d_step == 1);
      end
      if (f_next) begin
        f_next  = 1'b0;
        i_i_ren = 1'b0;
      end
      if (d_step < 2 && !o_d_busy) begin
        if (d_step == 0) begin
          ref_write(d_addr, 4'b1111, wdata);
        end else begin
          check_word("data after fetch", reverse_bytes(ref_mem[d_addr[9:2]]), o_d_rdata);
        end
        order[2*d_step] = seen;
        seen++;
        d_step++;
        d_next = 1'b1;
      end
      if (!f_done && !o_i_busy) begin
        check_word("contended fetch", reverse_bytes(ref_mem[f_addr[9:2]]), o_i_rdata);
        order[1] = seen;
        seen++;
        f_done = 1'b1;
        f_next = 1'b1;
      end
    end
    if (d_step < 2 || !f_done) begin
      $display("Timeout at %0t: contention sequence did not finish", $time);
      errors++;
    end else if (order[0] != 0 || order[1] != 1 || order[2] != 2) begin
      $display("mismatch at %0t: completion order expected 0 1 2 got %0d %0d %0d", $time,
               order[0], order[1], order[2]);
      errors++;
    end
    @(negedge CLK);
    idle_ports();
  endtask

  initial begin
    seed   = 32'hd9e1;
    errors = 0;
    nRST   = 1'b0;
    idle_ports();
    repeat (5) @(negedge CLK);
    nRST = 1'b1;
    reset_test();
    round_trip_test();
    partial_write_test();
    fetch_test();
    contention_test();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- tb/mem_subsystem_checker.sv
`timescale 1ns/10ps

module mem_subsystem_checker #(
  parameter int WAIT_CYCLES = 2
) (
  input logic CLK,
  input logic nRST,
  input logic i_bus_ren,
  input logic i_bus_wen,
  input logic i_d_ren,
  input logic i_d_wen,
  input logic i_i_ren,
  input logic i_d_busy,
  input logic i_i_busy
);

  localparam int LIMIT = WAIT_CYCLES + 3;

  logic d_req;
  int   d_wait;
  int   i_wait;

  assign d_req = i_d_ren | i_d_wen;

  // Cycles a port has been kept busy while the other port asks for nothing.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      d_wait <= 0;
      i_wait <= 0;
    end else begin
      d_wait <= (d_req && i_d_busy && !i_i_ren) ? d_wait + 1 : 0;
      i_wait <= (i_i_ren && i_i_busy && !d_req) ? i_wait + 1 : 0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Protocol and arbiter properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assert property (@(posedge CLK) disable iff (!nRST) !(i_bus_ren && i_bus_wen))
    else $error("Bus read and write are high together.");

  assert property (@(posedge CLK) disable iff (!nRST) (i_d_busy || i_i_busy))
    else $error("Both ports see busy low in the same cycle.");

  assert property (@(posedge CLK) $rose(nRST) |-> (i_d_busy && i_i_busy))
    else $error("A port busy is low right after reset.");

  assert property (@(posedge CLK) disable iff (!nRST) (d_wait < LIMIT && i_wait < LIMIT))
    else $error("A lone request was not completed in time.");

endmodule

bind mem_subsystem mem_subsystem_checker #(
  .WAIT_CYCLES (WAIT_CYCLES)
) u_checker (
  .CLK       (CLK),
  .nRST      (nRST),
  .i_bus_ren (bus_ren),
  .i_bus_wen (bus_wen),
  .i_d_ren   (i_d_ren),
  .i_d_wen   (i_d_wen),
  .i_i_ren   (i_i_ren),
  .i_d_busy  (o_d_busy),
  .i_i_busy  (o_i_busy)
);

//--- hw/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem
  import mem_pkg::*;
#(
  parameter string BUS_ENDIANNESS = "little",
  parameter int    RAM_WORDS      = 256,
  parameter int    WAIT_CYCLES    = 2
) (
  input  logic              CLK,
  input  logic              nRST,

  // Data load/store port.
  input  logic              i_d_ren,
  input  logic              i_d_wen,
  input  logic [ADDR_W-1:0] i_d_addr,
  input  logic [BE_W-1:0]   i_d_byte_en,
  input  logic [DATA_W-1:0] i_d_wdata,
  output logic [DATA_W-1:0] o_d_rdata,
  output logic              o_d_busy,

  // Instruction fetch port.
  input  logic              i_i_ren,
  input  logic [ADDR_W-1:0] i_i_addr,
  output logic [DATA_W-1:0] o_i_rdata,
  output logic              o_i_busy
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shared bus between the arbiter, the aligner and the RAM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic              bus_ren;
  logic              bus_wen;
  logic [ADDR_W-1:0] bus_addr;
  logic [BE_W-1:0]   bus_byte_en;
  logic [DATA_W-1:0] bus_wdata;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_busy;
  logic [DATA_W-1:0] rdata;

  memory_controller u_ctrl (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_d_ren       (i_d_ren),
    .i_d_wen       (i_d_wen),
    .i_d_addr      (i_d_addr),
    .i_d_byte_en   (i_d_byte_en),
    .o_d_busy      (o_d_busy),
    .i_i_ren       (i_i_ren),
    .i_i_addr      (i_i_addr),
    .o_i_busy      (o_i_busy),
    .o_bus_ren     (bus_ren),
    .o_bus_wen     (bus_wen),
    .o_bus_addr    (bus_addr),
    .o_bus_byte_en (bus_byte_en),
    .i_bus_busy    (bus_busy)
  );

  byte_lane_aligner #(
    .BUS_ENDIANNESS (BUS_ENDIANNESS)
  ) u_align (
    .i_wdata     (i_d_wdata),
    .i_byte_en   (i_d_byte_en),
    .o_bus_wdata (bus_wdata),
    .i_bus_rdata (bus_rdata),
    .o_rdata     (rdata)
  );

  wait_state_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_ram (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_ren     (bus_ren),
    .i_wen     (bus_wen),
    .i_addr    (bus_addr),
    .i_byte_en (bus_byte_en),
    .i_wdata   (bus_wdata),
    .o_rdata   (bus_rdata),
    .o_busy    (bus_busy)
  );

  // Both ports get the same converted read word.
  assign o_d_rdata = rdata;
  assign o_i_rdata = rdata;

endmodule

//--- hw/wait_state_ram.sv
`timescale 1ns/10ps

module wait_state_ram
  import mem_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int WAIT_CYCLES = 2
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              i_ren,
  input  logic              i_wen,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [BE_W-1:0]   i_byte_en,
  input  logic [DATA_W-1:0] i_wdata,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_busy
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

  // Counter value of the one cycle in which the access completes.
  localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(WAIT_CYCLES);

  logic [DATA_W-1:0] mem [RAM_WORDS];

  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] word_idx;
  logic             access;
  logic             done;

  assign access = i_ren | i_wen;

  // Byte address to word index, the low two bits select a byte lane.
  assign word_idx = i_addr[IDX_W+1:2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wait counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The counter runs from the first cycle of an access. It holds zero
  // while nothing is requested.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (done) begin
      // Back to zero after a completion, so a request that is still
      // held in this cycle does not get served a second time.
      wait_cnt <= '0;
    end else if (access) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  assign done   = (wait_cnt == CNT_DONE);
  assign o_busy = ~done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word array
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A write lands only in the completion cycle and only in enabled lanes.
  always_ff @(posedge CLK) begin
    if (done && i_wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (i_byte_en[b]) begin
          mem[word_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data is taken straight from the array. The requester samples
  // it in the cycle busy is low.
  assign o_rdata = mem[word_idx];

endmodule

//--- hw/memory_controller.sv
`timescale 1ns/10ps

module memory_controller
  import mem_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,

  // Data load/store port.
  input  logic              i_d_ren,
  input  logic              i_d_wen,
  input  logic [ADDR_W-1:0] i_d_addr,
  input  logic [BE_W-1:0]   i_d_byte_en,
  output logic              o_d_busy,

  // Instruction fetch port, read only.
  input  logic              i_i_ren,
  input  logic [ADDR_W-1:0] i_i_addr,
  output logic              o_i_busy,

  // Shared memory bus.
  output logic              o_bus_ren,
  output logic              o_bus_wen,
  output logic [ADDR_W-1:0] o_bus_addr,
  output logic [BE_W-1:0]   o_bus_byte_en,
  input  logic              i_bus_busy
);

  arb_state_t state;
  arb_state_t next_state;

  logic d_req;
  logic i_req;
  logic bus_done;

  // A data request is either direction, a fetch is only ever a read.
  assign d_req    = i_d_ren | i_d_wen;
  assign i_req    = i_i_ren;
  assign bus_done = ~i_bus_busy;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= ARB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Data has priority only when the bus is idle. Once an access
  // completes, the other port gets the next turn if it is waiting, so
  // a stream of data accesses cannot lock out instruction fetches.
  always_comb begin
    next_state = state;
    case (state)
      ARB_IDLE: begin
        if (d_req) begin
          next_state = ARB_DATA;
        end else if (i_req) begin
          next_state = ARB_INSTR;
        end else begin
          next_state = ARB_IDLE;
        end
      end

      ARB_DATA: begin
        if (bus_done) begin
          if (i_req) begin
            next_state = ARB_INSTR;
          end else begin
            next_state = ARB_IDLE;
          end
        end
      end

      ARB_INSTR: begin
        if (bus_done) begin
          if (d_req) begin
            next_state = ARB_DATA;
          end else begin
            next_state = ARB_IDLE;
          end
        end
      end

      default: begin
        next_state = ARB_IDLE;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus multiplexer and busy steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Only the granted port sees the RAM busy. The port that is not
  // granted keeps busy high and must hold its request until its turn.
  always_comb begin
    o_bus_ren     = 1'b0;
    o_bus_wen     = 1'b0;
    o_bus_addr    = '0;
    o_bus_byte_en = '0;
    o_d_busy      = 1'b1;
    o_i_busy      = 1'b1;

    case (state)
      ARB_DATA: begin
        o_bus_ren     = i_d_ren;
        o_bus_wen     = i_d_wen;
        o_bus_addr    = i_d_addr;
        o_bus_byte_en = i_d_byte_en;
        o_d_busy      = i_bus_busy;
      end

      ARB_INSTR: begin
        // A fetch always reads the whole word.
        o_bus_ren     = i_i_ren;
        o_bus_wen     = 1'b0;
        o_bus_addr    = i_i_addr;
        o_bus_byte_en = '1;
        o_i_busy      = i_bus_busy;
      end

      default: begin
        o_bus_ren     = 1'b0;
        o_bus_wen     = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/byte_lane_aligner.sv
`timescale 1ns/10ps

module byte_lane_aligner
  import mem_pkg::*;
#(
  parameter string BUS_ENDIANNESS = "little"
) (
  input  logic [DATA_W-1:0] i_wdata,
  input  logic [BE_W-1:0]   i_byte_en,
  output logic [DATA_W-1:0] o_bus_wdata,
  input  logic [DATA_W-1:0] i_bus_rdata,
  output logic [DATA_W-1:0] o_rdata
);

  logic [DATA_W-1:0] conv_wdata;

  // Reverses the order of the bytes in one word.
  function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] word);
    logic [DATA_W-1:0] swapped;
    for (int b = 0; b < BE_W; b++) begin
      swapped[8*b +: 8] = word[8*(BE_W-1-b) +: 8];
    end
    return swapped;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Byte order conversion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  generate
    if (BUS_ENDIANNESS == "big") begin : g_big
      assign conv_wdata = i_wdata;
      assign o_rdata    = i_bus_rdata;
    end else begin : g_little
      // Little endian swaps both directions, so a round trip is unchanged.
      assign conv_wdata = swap_bytes(i_wdata);
      assign o_rdata    = swap_bytes(i_bus_rdata);
    end
  endgenerate

  // Move the converted data into the lanes picked by the byte enables.
  always_comb begin
    case (i_byte_en)
      4'b1111, 4'b0011, 4'b0001: o_bus_wdata = conv_wdata;
      4'b0010:                   o_bus_wdata = conv_wdata << 8;
      4'b0100, 4'b1100:          o_bus_wdata = conv_wdata << 16;
      4'b1000:                   o_bus_wdata = conv_wdata << 24;
      default:                   o_bus_wdata = conv_wdata;
    endcase
  end

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Byte address width seen by both requester ports.
  localparam int ADDR_W = 32;

  // Width of one data word on the bus.
  localparam int DATA_W = 32;

  // One byte enable per byte lane.
  localparam int BE_W = DATA_W / 8;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbiter state encoding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ARB_IDLE has nothing on the bus, the other two name the granted port.
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'b00,
    ARB_DATA  = 2'b01,
    ARB_INSTR = 2'b10
  } arb_state_t;

endpackage
